// ==== source/mipsPkg.sv ====
package mipsPkg;

	//////////////////////////////////////////////////////////////
	// scalar types
	//////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [3:0]  aluCtrl_t;
	typedef logic [2:0]  memOp_t;
	typedef logic [1:0]  fwdSel_t;

	// alu operations
	localparam aluCtrl_t aluAdd = 4'd0;
	localparam aluCtrl_t aluSub = 4'd1;
	localparam aluCtrl_t aluAnd = 4'd2;
	localparam aluCtrl_t aluOr  = 4'd3;
	localparam aluCtrl_t aluSlt = 4'd4;

	// memory access kinds, memNone must stay zero
	localparam memOp_t memNone = 3'd0;
	localparam memOp_t memLw   = 3'd1;
	localparam memOp_t memLb   = 3'd2;
	localparam memOp_t memLbu  = 3'd3;
	localparam memOp_t memSw   = 3'd4;
	localparam memOp_t memSb   = 3'd5;

	// forwarding sources for execute
	localparam fwdSel_t fwdReg = 2'd0;
	localparam fwdSel_t fwdMem = 2'd1;
	localparam fwdSel_t fwdWb  = 2'd2;

	// opcode field
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLb    = 6'h20;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opLbu   = 6'h24;
	localparam logic [5:0] opSb    = 6'h28;
	localparam logic [5:0] opSw    = 6'h2b;

	// funct field of r-type
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	//////////////////////////////////////////////////////////////
	// pipeline structs
	//////////////////////////////////////////////////////////////

	typedef struct packed {
		logic     regWrite;
		logic     regDst;   // rd instead of rt
		logic     aluSrc;   // immediate as operand b
		logic     zeroExt;
		memOp_t   memOp;
		aluCtrl_t aluCtrl;
		logic     branch;
		logic     jump;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc;
		word_t    srcA;
		word_t    srcB;
		word_t    imm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
	} idEx_t;

	typedef struct packed {
		logic     regWrite;
		memOp_t   memOp;
		word_t    pc;
		word_t    aluOut;
		word_t    storeData;
		regAddr_t writeReg;
	} exMem_t;

	typedef struct packed {
		logic     regWrite;
		word_t    pc;
		word_t    result;
		regAddr_t writeReg;
	} memWb_t;

	// data port towards memory
	typedef struct packed {
		word_t      addr;
		word_t      wdata;
		logic [3:0] byteEn;
		logic       write;
	} dataReq_t;

	// register write trace
	typedef struct packed {
		word_t    pc;
		logic     wen;
		regAddr_t wnum;
		word_t    wdata;
	} wbTrace_t;

	// access kind helpers
	function automatic logic isLoad(memOp_t op);
		return (op == memLw) || (op == memLb) || (op == memLbu);
	endfunction

	function automatic logic isStore(memOp_t op);
		return (op == memSw) || (op == memSb);
	endfunction

endpackage

// ==== source/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
	input  mipsPkg::word_t instr,
	output mipsPkg::ctrl_t ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		// default is a nop, nothing written
		ctrl = '0;
		case (opcode)
			mipsPkg::opRtype: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAddu: ctrl.aluCtrl = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctrl.aluCtrl = mipsPkg::aluSub;
					mipsPkg::fnAnd:  ctrl.aluCtrl = mipsPkg::aluAnd;
					mipsPkg::fnOr:   ctrl.aluCtrl = mipsPkg::aluOr;
					mipsPkg::fnSlt:  ctrl.aluCtrl = mipsPkg::aluSlt;
					// sll $0 and friends fall here
					default: ctrl = '0;
				endcase
			end
			mipsPkg::opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = mipsPkg::aluAdd;
			end
			mipsPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.aluCtrl = mipsPkg::aluOr;
			end
			mipsPkg::opLw, mipsPkg::opLb, mipsPkg::opLbu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = mipsPkg::aluAdd;
				if (opcode == mipsPkg::opLw)
					ctrl.memOp = mipsPkg::memLw;
				else if (opcode == mipsPkg::opLb)
					ctrl.memOp = mipsPkg::memLb;
				else
					ctrl.memOp = mipsPkg::memLbu;
			end
			mipsPkg::opSw, mipsPkg::opSb: begin
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtrl = mipsPkg::aluAdd;
				ctrl.memOp = (opcode == mipsPkg::opSw) ? mipsPkg::memSw : mipsPkg::memSb;
			end
			// compare is done in decode, alu unused
			mipsPkg::opBeq: ctrl.branch = 1'b1;
			mipsPkg::opJ:   ctrl.jump = 1'b1;
			default:        ctrl = '0;
		endcase
	end

endmodule

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input  mipsPkg::word_t    srcA,
	input  mipsPkg::word_t    srcB,
	input  mipsPkg::aluCtrl_t aluCtrl,
	output mipsPkg::word_t    result
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (aluCtrl)
			// addu / addiu / address calc, no overflow trap
			mipsPkg::aluAdd: result = srcA + srcB;
			mipsPkg::aluSub: result = srcA - srcB;
			mipsPkg::aluAnd: result = srcA & srcB;
			mipsPkg::aluOr:  result = srcA | srcB;
			mipsPkg::aluSlt: result = {31'b0, lessThan};
			default:         result = '0;
		endcase
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic               clk,
	input  logic               arstN,
	input  logic               we,
	input  mipsPkg::regAddr_t  wAddr,
	input  mipsPkg::word_t     wData,
	input  mipsPkg::regAddr_t  rAddrA,
	input  mipsPkg::regAddr_t  rAddrB,
	output mipsPkg::word_t     rDataA,
	output mipsPkg::word_t     rDataB
);

	mipsPkg::word_t regs [32];

	// $0 never written
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// writeback bypass, so decode sees the value in the same cycle
	assign rDataA = (rAddrA == '0) ? '0 :
		(we && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (rAddrB == '0) ? '0 :
		(we && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
	input  mipsPkg::regAddr_t rsD,
	input  mipsPkg::regAddr_t rtD,
	input  logic              branchD,
	input  mipsPkg::idEx_t    idEx,
	input  mipsPkg::regAddr_t writeRegE,
	input  mipsPkg::exMem_t   exMem,
	input  mipsPkg::memWb_t   memWb,
	output logic              stallF,
	output logic              stallD,
	output logic              bubbleE,
	output mipsPkg::fwdSel_t  fwdAE,
	output mipsPkg::fwdSel_t  fwdBE,
	output logic              fwdAD,
	output logic              fwdBD
);

	logic loadUse;
	logic branchStall;
	logic exWritesD;
	logic memLoadsD;

	// memory stage wins over writeback, $0 never forwarded
	function automatic mipsPkg::fwdSel_t pickFwd(mipsPkg::regAddr_t src,
			mipsPkg::exMem_t em, mipsPkg::memWb_t mw);
		if (src != '0 && em.regWrite && em.writeReg == src)
			return mipsPkg::fwdMem;
		else if (src != '0 && mw.regWrite && mw.writeReg == src)
			return mipsPkg::fwdWb;
		else
			return mipsPkg::fwdReg;
	endfunction

	//////////////////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////////////////

	assign fwdAE = pickFwd(idEx.rs, exMem, memWb);
	assign fwdBE = pickFwd(idEx.rt, exMem, memWb);

	// beq compare taps the memory stage alu result only
	assign fwdAD = (rsD != '0) && exMem.regWrite && (exMem.writeReg == rsD);
	assign fwdBD = (rtD != '0) && exMem.regWrite && (exMem.writeReg == rtD);

	//////////////////////////////////////////////////////////////
	// stalls
	//////////////////////////////////////////////////////////////

	// load in execute feeding decode
	assign loadUse = mipsPkg::isLoad(idEx.ctrl.memOp) && (writeRegE != '0) &&
		((writeRegE == rsD) || (writeRegE == rtD));

	// execute result not ready for the compare yet
	assign exWritesD = idEx.ctrl.regWrite && (writeRegE != '0) &&
		((writeRegE == rsD) || (writeRegE == rtD));

	// load data only arrives at end of memory
	assign memLoadsD = mipsPkg::isLoad(exMem.memOp) && (exMem.writeReg != '0) &&
		((exMem.writeReg == rsD) || (exMem.writeReg == rtD));

	assign branchStall = branchD && (exWritesD || memLoadsD);

	// hold fetch and decode, empty slot into execute
	assign stallF  = loadUse | branchStall;
	assign stallD  = loadUse | branchStall;
	assign bubbleE = loadUse | branchStall;

endmodule

// ==== source/memAlign.sv ====
`timescale 1ns/1ps

module memAlign (
	input  mipsPkg::memOp_t memOp,
	input  mipsPkg::word_t  addr,
	input  mipsPkg::word_t  storeData,
	input  mipsPkg::word_t  readData,
	output logic [3:0]      byteEn,
	output mipsPkg::word_t  wdata,
	output mipsPkg::word_t  loadData
);

	logic [1:0] lane;
	logic [7:0] loadByte;

	assign lane = addr[1:0];

	//////////////////////////////////////////////////////////////
	// store side
	//////////////////////////////////////////////////////////////

	always_comb begin
		case (memOp)
			mipsPkg::memSw: byteEn = 4'b1111;
			// one lane, little endian
			mipsPkg::memSb: byteEn = 4'b0001 << lane;
			default:        byteEn = 4'b0000;
		endcase
	end

	// byte copied to every lane, byteEn picks the one written
	assign wdata = (memOp == mipsPkg::memSb) ? {4{storeData[7:0]}} : storeData;

	//////////////////////////////////////////////////////////////
	// load side
	//////////////////////////////////////////////////////////////

	always_comb begin
		case (lane)
			2'd0:    loadByte = readData[7:0];
			2'd1:    loadByte = readData[15:8];
			2'd2:    loadByte = readData[23:16];
			default: loadByte = readData[31:24];
		endcase
	end

	always_comb begin
		case (memOp)
			// lb sign extends
			mipsPkg::memLb:  loadData = {{24{loadByte[7]}}, loadByte};
			mipsPkg::memLbu: loadData = {24'b0, loadByte};
			// full word for lw and the rest
			default:         loadData = readData;
		endcase
	end

endmodule

// ==== source/mipsDatapath.sv ====
`timescale 1ns/1ps

module mipsDatapath (
	input  logic              clk,
	input  logic              arstN,
	output mipsPkg::word_t    pcF,
	input  mipsPkg::word_t    instrF,
	output mipsPkg::dataReq_t dataReqM,
	input  mipsPkg::word_t    readDataM,
	output mipsPkg::wbTrace_t debugWb
);

	// decode
	mipsPkg::word_t    instrD, pcD, pcPlus4D, immD;
	mipsPkg::word_t    rfA, rfB, cmpA, cmpB;
	mipsPkg::word_t    branchTarget, jumpTarget;
	mipsPkg::regAddr_t rsD, rtD, rdD;
	mipsPkg::ctrl_t    ctrlD;
	logic              takenD, fwdAD, fwdBD;
	// hazard controls
	logic              stallF, stallD, bubbleE;
	mipsPkg::fwdSel_t  fwdAE, fwdBE;
	// execute
	mipsPkg::idEx_t    idExR;
	mipsPkg::word_t    srcAE, srcBE, aluBE, aluOutE;
	mipsPkg::regAddr_t writeRegE;
	// memory and writeback
	mipsPkg::exMem_t   exMemR;
	mipsPkg::memWb_t   memWbR;
	mipsPkg::word_t    loadDataM, resultM;

	// execute operand select
	function automatic mipsPkg::word_t fwdMux(mipsPkg::fwdSel_t sel,
			mipsPkg::word_t regVal, mipsPkg::word_t memVal, mipsPkg::word_t wbVal);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pcF <= '0;
		else if (!stallF)
			pcF <= takenD ? (ctrlD.jump ? jumpTarget : branchTarget) : pcF + 32'd4;
	end

	// fetch to decode, taken redirect squashes with an all-zero nop
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
			pcD <= '0;
		end else if (!stallD) begin
			instrD <= takenD ? '0 : instrF;
			pcD <= pcF;
		end
	end

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = ctrlD.zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

	mainDecoder decoder0 (.instr(instrD), .ctrl(ctrlD));

	regFile regFile0 (
		.clk(clk), .arstN(arstN),
		.we(memWbR.regWrite), .wAddr(memWbR.writeReg), .wData(memWbR.result),
		.rAddrA(rsD), .rAddrB(rtD), .rDataA(rfA), .rDataB(rfB)
	);

	// branch and jump resolve here
	assign pcPlus4D = pcD + 32'd4;
	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};
	assign cmpA = fwdAD ? exMemR.aluOut : rfA;
	assign cmpB = fwdBD ? exMemR.aluOut : rfB;
	// no redirect while operands are still pending
	assign takenD = ((ctrlD.branch && cmpA == cmpB) || ctrlD.jump) && !stallD;

	hazardUnit hazard0 (
		.rsD(rsD), .rtD(rtD), .branchD(ctrlD.branch),
		.idEx(idExR), .writeRegE(writeRegE), .exMem(exMemR), .memWb(memWbR),
		.stallF(stallF), .stallD(stallD), .bubbleE(bubbleE),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			idExR <= '0;
		else if (bubbleE)
			idExR <= '0;
		else
			idExR <= '{ctrl: ctrlD, pc: pcD, srcA: rfA, srcB: rfB, imm: immD,
				rs: rsD, rt: rtD, rd: rdD};
	end

	////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////

	assign srcAE = fwdMux(fwdAE, idExR.srcA, exMemR.aluOut, memWbR.result);
	assign srcBE = fwdMux(fwdBE, idExR.srcB, exMemR.aluOut, memWbR.result);
	assign aluBE = idExR.ctrl.aluSrc ? idExR.imm : srcBE;
	assign writeRegE = idExR.ctrl.regDst ? idExR.rd : idExR.rt;

	aluUnit alu0 (.srcA(srcAE), .srcB(aluBE), .aluCtrl(idExR.ctrl.aluCtrl), .result(aluOutE));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			exMemR <= '0;
		else
			exMemR <= '{regWrite: idExR.ctrl.regWrite, memOp: idExR.ctrl.memOp,
				pc: idExR.pc, aluOut: aluOutE, storeData: srcBE, writeReg: writeRegE};
	end

	////////////////////////////////////////////////////////////
	// memory
	////////////////////////////////////////////////////////////

	memAlign align0 (
		.memOp(exMemR.memOp), .addr(exMemR.aluOut), .storeData(exMemR.storeData),
		.readData(readDataM), .byteEn(dataReqM.byteEn), .wdata(dataReqM.wdata),
		.loadData(loadDataM)
	);

	assign dataReqM.addr = exMemR.aluOut;
	assign dataReqM.write = mipsPkg::isStore(exMemR.memOp);
	assign resultM = mipsPkg::isLoad(exMemR.memOp) ? loadDataM : exMemR.aluOut;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			memWbR <= '0;
		else
			memWbR <= '{regWrite: exMemR.regWrite, pc: exMemR.pc, result: resultM,
				writeReg: exMemR.writeReg};
	end

	////////////////////////////////////////////////////////////
	// writeback trace
	////////////////////////////////////////////////////////////

	assign debugWb.pc = memWbR.pc;
	assign debugWb.wen = memWbR.regWrite && (memWbR.writeReg != '0);
	assign debugWb.wnum = memWbR.writeReg;
	assign debugWb.wdata = memWbR.result;

endmodule

// ==== sim/tbPrograms.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

////////////////////////////////////////////////////////////
// encoders
////////////////////////////////////////////////////////////

// data memory contents after reset, distinct for every word
function automatic mipsPkg::word_t fillWord(int idx);
	return (mipsPkg::word_t'(idx) * 32'h9e37_79b9) ^ 32'h8040_2010;
endfunction

// absolute jump, target given as byte address
function automatic mipsPkg::word_t encJ(mipsPkg::word_t target);
	return {mipsPkg::opJ, target[27:2]};
endfunction

task automatic putR(logic [5:0] fn, int rd, int rs, int rt);
	prog.push_back({mipsPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn});
endtask

// operand order as in assembler, rt first
task automatic putI(logic [5:0] op, int rt, int rs, int imm);
	prog.push_back({op, rs[4:0], rt[4:0], imm[15:0]});
endtask

task automatic putJ(int target);
	prog.push_back(encJ(mipsPkg::word_t'(target)));
endtask

////////////////////////////////////////////////////////////
// sequential reference model
////////////////////////////////////////////////////////////

// one instruction per step, no pipeline, fills the expected queues
task automatic modelRun(mipsPkg::word_t haltPc);
	mipsPkg::word_t    r [32];
	mipsPkg::word_t    md [256];
	mipsPkg::word_t    pc;
	mipsPkg::word_t    pc4;
	mipsPkg::word_t    nextPc;
	mipsPkg::word_t    ins;
	mipsPkg::word_t    a;
	mipsPkg::word_t    b;
	mipsPkg::word_t    sImm;
	mipsPkg::word_t    addr;
	mipsPkg::word_t    wVal;
	mipsPkg::regAddr_t wNum;
	logic              wr;
	logic [7:0]        bt;
	int                steps;
	for (int i = 0; i < 32; i++)
		r[i] = '0;
	for (int i = 0; i < 256; i++)
		md[i] = fillWord(i);
	pc = '0;
	steps = 0;
	while (pc != haltPc && steps < 2000) begin
		ins = imem[pc[9:2]];
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		addr = a + sImm;
		// addressed byte, little endian
		bt = md[addr[9:2]][{addr[1:0], 3'b000} +: 8];
		pc4 = pc + 32'd4;
		nextPc = pc4;
		wr = 1'b0;
		wNum = ins[20:16];
		wVal = '0;
		case (ins[31:26])
			mipsPkg::opRtype: begin
				wNum = ins[15:11];
				wr = 1'b1;
				case (ins[5:0])
					mipsPkg::fnAddu: wVal = a + b;
					mipsPkg::fnSubu: wVal = a - b;
					mipsPkg::fnAnd:  wVal = a & b;
					mipsPkg::fnOr:   wVal = a | b;
					mipsPkg::fnSlt:  wVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:         wr = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: begin
				wr = 1'b1;
				wVal = a + sImm;
			end
			mipsPkg::opOri: begin
				wr = 1'b1;
				wVal = a | {16'b0, ins[15:0]};
			end
			mipsPkg::opLw: begin
				wr = 1'b1;
				wVal = md[addr[9:2]];
			end
			mipsPkg::opLb: begin
				wr = 1'b1;
				wVal = {{24{bt[7]}}, bt};
			end
			mipsPkg::opLbu: begin
				wr = 1'b1;
				wVal = {24'b0, bt};
			end
			mipsPkg::opSw: begin
				md[addr[9:2]] = b;
				expStAddr.push_back(addr);
				expStBe.push_back(4'b1111);
				expStData.push_back(b);
			end
			// byte sits on every lane of the port
			mipsPkg::opSb: begin
				md[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
				expStAddr.push_back(addr);
				expStBe.push_back(4'b0001 << addr[1:0]);
				expStData.push_back({4{b[7:0]}});
			end
			mipsPkg::opBeq: begin
				if (a == b)
					nextPc = pc4 + {sImm[29:0], 2'b00};
			end
			mipsPkg::opJ: nextPc = {pc4[31:28], ins[25:0], 2'b00};
			default: wr = 1'b0;
		endcase
		// $0 stays zero and leaves no trace
		if (wr && wNum != '0) begin
			r[wNum] = wVal;
			expPc.push_back(pc);
			expNum.push_back(wNum);
			expData.push_back(wVal);
		end
		pc = nextPc;
		steps++;
	end
endtask

`endif

// ==== sim/mipsDatapathTb.sv ====
`timescale 1ns/1ps

module mipsDatapathTb;

	logic              clk;
	logic              arstN;
	mipsPkg::word_t    pcF;
	mipsPkg::word_t    instrF;
	mipsPkg::dataReq_t dataReqM;
	mipsPkg::word_t    readDataM;
	mipsPkg::wbTrace_t debugWb;

	// word addressed, 1 KiB each
	mipsPkg::word_t imem [256];
	mipsPkg::word_t dmem [256];
	mipsPkg::word_t prog [$];

	// expected writes and stores in program order
	mipsPkg::word_t    expPc [$];
	mipsPkg::regAddr_t expNum [$];
	mipsPkg::word_t    expData [$];
	mipsPkg::word_t    expStAddr [$];
	logic [3:0]        expStBe [$];
	mipsPkg::word_t    expStData [$];

	logic checking;
	int   valErrs;
	int   seqErrs;
	int   seed = 32'hc56a_e0df;

	`include "tbPrograms.svh"

	mipsDatapath dut0 (
		.clk(clk), .arstN(arstN), .pcF(pcF), .instrF(instrF),
		.dataReqM(dataReqM), .readDataM(readDataM), .debugWb(debugWb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// memory models
	////////////////////////////////////////////////////////////

	// both ports answer in the same cycle
	assign instrF = imem[pcF[9:2]];
	assign readDataM = dmem[dataReqM.addr[9:2]];

	always @(posedge clk) begin
		if (dataReqM.write) begin
			for (int b = 0; b < 4; b++) begin
				if (dataReqM.byteEn[b])
					dmem[dataReqM.addr[9:2]][8*b +: 8] <= dataReqM.wdata[8*b +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic checkVal(string name, mipsPkg::word_t got, mipsPkg::word_t exp);
		assert (got === exp) else begin
			valErrs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkIdle();
		checkVal("pcF", pcF, 32'd0);
		checkVal("dataReqM.write", {31'b0, dataReqM.write}, 32'd0);
		checkVal("debugWb.wen", {31'b0, debugWb.wen}, 32'd0);
	endtask

	task automatic compareWrite();
		mipsPkg::regAddr_t num;
		if (expPc.size() == 0) begin
			seqErrs++;
			$display("register $%0d written at pc %h after the last expected write",
				debugWb.wnum, debugWb.pc);
		end else begin
			num = expNum.pop_front();
			checkVal("debugWb.pc", debugWb.pc, expPc.pop_front());
			checkVal("debugWb.wnum", {27'b0, debugWb.wnum}, {27'b0, num});
			checkVal("debugWb.wdata", debugWb.wdata, expData.pop_front());
		end
	endtask

	task automatic compareStore();
		logic [3:0] be;
		if (expStAddr.size() == 0) begin
			seqErrs++;
			$display("store to address %h that the program never makes", dataReqM.addr);
		end else begin
			be = expStBe.pop_front();
			checkVal("dataReqM.addr", dataReqM.addr, expStAddr.pop_front());
			checkVal("dataReqM.byteEn", {28'b0, dataReqM.byteEn}, {28'b0, be});
			checkVal("dataReqM.wdata", dataReqM.wdata, expStData.pop_front());
		end
	endtask

	// mid-cycle sampling, outputs settled
	always @(negedge clk) begin
		if (checking && debugWb.wen)
			compareWrite();
		if (checking && dataReqM.write)
			compareStore();
	end

	////////////////////////////////////////////////////////////
	// program runner
	////////////////////////////////////////////////////////////

	// every unused slot holds a jump to itself
	task automatic loadImage();
		for (int i = 0; i < 256; i++) begin
			imem[i] = encJ(mipsPkg::word_t'(i) << 2);
			dmem[i] <= fillWord(i);
		end
		foreach (prog[k])
			imem[k] = prog[k];
	endtask

	task automatic holdReset();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			checkIdle();
		end
		@(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkIdle();
	endtask

	task automatic runProgram(string name);
		mipsPkg::word_t haltPc;
		int hits;
		int cycles;
		haltPc = prog.size() << 2;
		@(posedge clk);
		arstN <= 1'b0;
		expPc.delete();
		expNum.delete();
		expData.delete();
		expStAddr.delete();
		expStBe.delete();
		expStData.delete();
		loadImage();
		modelRun(haltPc);
		checking = 1'b1;
		holdReset();
		// halt jump keeps pcF bouncing back to its own address
		hits = 0;
		cycles = 0;
		while (hits < 6 && cycles < 3000) begin
			@(negedge clk);
			cycles++;
			if (pcF == haltPc)
				hits++;
		end
		if (hits < 6) begin
			seqErrs++;
			$display("%s: halt loop not reached within %0d cycles", name, cycles);
		end
		// drain the pipe
		for (int i = 0; i < 8; i++)
			@(negedge clk);
		@(posedge clk);
		checking = 1'b0;
		if (expPc.size() != 0) begin
			seqErrs++;
			$display("%s: %0d register writes never reached writeback", name, expPc.size());
		end
		if (expStAddr.size() != 0) begin
			seqErrs++;
			$display("%s: %0d stores never reached the data port", name, expStAddr.size());
		end
		$display("%s: finished after %0d cycles", name, cycles);
		prog.delete();
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	// writes to $0 only, trace must stay empty
	task automatic testReset();
		putI(mipsPkg::opAddiu, 0, 0, 'h7f);
		putR(mipsPkg::fnAddu, 0, 0, 0);
		putI(mipsPkg::opOri, 0, 0, 'h55aa);
		putR(mipsPkg::fnSlt, 0, 0, 0);
		runProgram("reset");
	endtask

	task automatic testForwarding();
		putI(mipsPkg::opAddiu, 1, 0, 'h0012);
		putI(mipsPkg::opAddiu, 2, 0, -3);
		// $2 from memory, $1 from writeback
		putR(mipsPkg::fnAddu, 3, 1, 2);
		putR(mipsPkg::fnSubu, 4, 3, 1);
		putR(mipsPkg::fnAnd, 5, 4, 3);
		putR(mipsPkg::fnOr, 6, 5, 2);
		putR(mipsPkg::fnSlt, 7, 2, 6);
		putI(mipsPkg::opOri, 8, 7, 'h8001);
		putI(mipsPkg::opAddiu, 9, 8, 'h7fff);
		putR(mipsPkg::fnSlt, 10, 9, 2);
		putR(mipsPkg::fnSubu, 11, 10, 9);
		putI(mipsPkg::opOri, 12, 11, 'h00f0);
		runProgram("forwarding");
	endtask

	task automatic testLoadUse();
		putI(mipsPkg::opAddiu, 1, 0, 'h40);
		putI(mipsPkg::opLw, 2, 1, 0);
		putR(mipsPkg::fnAddu, 3, 2, 2);
		putI(mipsPkg::opLw, 4, 1, 4);
		putR(mipsPkg::fnSubu, 5, 4, 2);
		putI(mipsPkg::opSw, 5, 1, 8);
		putI(mipsPkg::opLw, 6, 1, 8);
		putR(mipsPkg::fnOr, 7, 0, 6);
		// loaded value straight into store data
		putI(mipsPkg::opLw, 8, 1, 12);
		putI(mipsPkg::opSw, 8, 1, 16);
		putI(mipsPkg::opLw, 9, 1, 16);
		putI(mipsPkg::opAddiu, 10, 9, 1);
		runProgram("load-use");
	endtask

	task automatic testByteMem();
		putI(mipsPkg::opAddiu, 1, 0, 'h80);
		putI(mipsPkg::opAddiu, 2, 0, 'ha5f1);
		putI(mipsPkg::opSw, 2, 1, 0);
		putI(mipsPkg::opAddiu, 3, 0, 'h81);
		putI(mipsPkg::opSb, 3, 1, 4);
		putI(mipsPkg::opAddiu, 3, 0, 'h7f);
		putI(mipsPkg::opSb, 3, 1, 5);
		putI(mipsPkg::opSb, 2, 1, 6);
		putI(mipsPkg::opAddiu, 4, 0, 'h0c);
		putI(mipsPkg::opSb, 4, 1, 7);
		putI(mipsPkg::opLw, 5, 1, 4);
		putI(mipsPkg::opLb, 6, 1, 4);
		putI(mipsPkg::opLbu, 7, 1, 4);
		putI(mipsPkg::opLb, 8, 1, 5);
		putI(mipsPkg::opLb, 9, 1, 6);
		putI(mipsPkg::opLbu, 10, 1, 7);
		putI(mipsPkg::opLbu, 11, 1, 1);
		putI(mipsPkg::opLb, 12, 1, 3);
		// one byte merged into a filled word
		putI(mipsPkg::opSb, 2, 1, 9);
		putI(mipsPkg::opLw, 13, 1, 8);
		runProgram("byte memory");
	endtask

	task automatic testControl();
		putI(mipsPkg::opAddiu, 1, 0, 5);
		putI(mipsPkg::opAddiu, 2, 0, 5);
		putI(mipsPkg::opBeq, 2, 1, 1);
		putI(mipsPkg::opAddiu, 3, 0, 'h99);
		putI(mipsPkg::opAddiu, 4, 0, 1);
		putI(mipsPkg::opBeq, 0, 4, 1);
		putI(mipsPkg::opAddiu, 5, 0, 2);
		putJ(40);
		putI(mipsPkg::opAddiu, 6, 0, 'h66);
		putI(mipsPkg::opAddiu, 7, 0, 'h77);
		// beq on a load, stalls twice
		putI(mipsPkg::opLw, 8, 0, 'h40);
		putI(mipsPkg::opBeq, 8, 8, 1);
		putI(mipsPkg::opAddiu, 9, 0, 'h99);
		// countdown loop
		putI(mipsPkg::opAddiu, 10, 0, 3);
		putI(mipsPkg::opAddiu, 10, 10, -1);
		putI(mipsPkg::opBeq, 0, 10, 1);
		putJ(56);
		putI(mipsPkg::opAddiu, 11, 0, 'h11);
		runProgram("control flow");
	endtask

	task automatic testRandom();
		logic [5:0] fnList [5];
		logic [31:0] rnd;
		int k;
		fnList = '{mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd,
			mipsPkg::fnOr, mipsPkg::fnSlt};
		for (int r = 1; r < 16; r++) begin
			rnd = $random(seed);
			putI(mipsPkg::opAddiu, r, 0, int'(rnd[15:0]));
		end
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			k = int'(rnd[2:0]) % 5;
			putR(fnList[k], 1 + int'(rnd[7:4]) % 15, int'(rnd[12:9]), int'(rnd[17:14]));
		end
		runProgram("random arithmetic");
	endtask

	initial begin
		arstN = 1'b0;
		checking = 1'b0;
		valErrs = 0;
		seqErrs = 0;
		loadImage();
		testReset();
		testForwarding();
		testLoadUse();
		testByteMem();
		testControl();
		testRandom();
		$display("value errors %0d, sequence errors %0d", valErrs, seqErrs);
		if (valErrs == 0 && seqErrs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== mipsPipe.f ====
+incdir+sim
source/mipsPkg.sv
source/mainDecoder.sv
source/aluUnit.sv
source/regFile.sv
source/hazardUnit.sv
source/memAlign.sv
source/mipsDatapath.sv
sim/mipsDatapathTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mipsPipe.f --top-module mipsDatapathTb -Mdir obj_dir
./obj_dir/VmipsDatapathTb | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation ok"
	exit 0
fi
echo "simulation reported errors"
exit 1
